// ==== source/hart_pkg.sv ====
package hart_pkg;

    // ==========================================================================
    // Widths
    // ==========================================================================
    localparam int xlen = 32;
    localparam int ilen = 32;

    typedef logic [4:0]      reg_index_t;
    typedef logic [xlen-1:0] word_t;

    // ==========================================================================
    // Major opcodes
    // ==========================================================================
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;

    // Decoded operation
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_addi,
        op_lw,
        op_sw,
        op_jal,
        op_unknown
    } op_t;

    // Where the register write value comes from
    typedef enum logic {
        wb_from_compute,
        wb_from_memory
    } wb_source_t;

endpackage

// ==== source/instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory import hart_pkg::*; #(
    parameter int imem_words = 64
) (
    input  logic  clock,
    input  logic  write_enable,
    input  word_t write_addr,
    input  word_t write_data,
    input  word_t read_addr,
    output word_t read_data
);

    localparam int addr_bits = $clog2(imem_words);

    word_t rom [imem_words];

    // Both addresses are byte offsets into the ROM
    always_ff @(posedge clock) begin
        if (write_enable) begin
            rom[write_addr[addr_bits+1:2]] <= write_data;
        end
        read_data <= rom[read_addr[addr_bits+1:2]];
    end

endmodule

// ==== source/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder import hart_pkg::*; (
    input  word_t      instruction,
    output op_t        op,
    output reg_index_t rs1,
    output reg_index_t rs2,
    output reg_index_t rd,
    output word_t      immediate,
    output logic       reg_write,
    output wb_source_t wb_source
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_j;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                    instruction[30:21], 1'b0};

    // Unused source fields stay at x0 so they never match a pending write
    always_comb begin
        op        = op_unknown;
        rs1       = '0;
        rs2       = '0;
        rd        = '0;
        immediate = '0;
        reg_write = 1'b0;
        wb_source = wb_from_compute;
        case (opcode)
            opcode_op: begin
                if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
                    op        = (funct7 == 7'b0100000) ? op_sub : op_add;
                    rs1       = instruction[19:15];
                    rs2       = instruction[24:20];
                    rd        = instruction[11:7];
                    reg_write = 1'b1;
                end
            end
            opcode_op_imm: begin
                if (funct3 == 3'b000) begin
                    op        = op_addi;
                    rs1       = instruction[19:15];
                    rd        = instruction[11:7];
                    immediate = imm_i;
                    reg_write = 1'b1;
                end
            end
            opcode_load: begin
                if (funct3 == 3'b010) begin
                    op        = op_lw;
                    rs1       = instruction[19:15];
                    rd        = instruction[11:7];
                    immediate = imm_i;
                    reg_write = 1'b1;
                    wb_source = wb_from_memory;
                end
            end
            opcode_store: begin
                if (funct3 == 3'b010) begin
                    op        = op_sw;
                    rs1       = instruction[19:15];
                    rs2       = instruction[24:20];
                    immediate = imm_s;
                end
            end
            opcode_jal: begin
                op        = op_jal;
                rd        = instruction[11:7];
                immediate = imm_j;
                reg_write = 1'b1;
            end
            default: begin
                op = op_unknown;
            end
        endcase
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file import hart_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  reg_index_t rs1,
    input  reg_index_t rs2,
    input  logic       write_enable,
    input  reg_index_t write_index,
    input  word_t      write_value,
    output word_t      rs1_value,
    output word_t      rs2_value
);

    word_t regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_index != '0) begin
            regs[write_index] <= write_value;
        end
    end

    // Write-first reads, x0 wired to zero
    always_ff @(posedge clock) begin
        if (rs1 == '0) rs1_value <= '0;
        else if (write_enable && write_index == rs1) rs1_value <= write_value;
        else rs1_value <= regs[rs1];

        if (rs2 == '0) rs2_value <= '0;
        else if (write_enable && write_index == rs2) rs2_value <= write_value;
        else rs2_value <= regs[rs2];
    end

endmodule

// ==== source/operand_forwarder.sv ====
`timescale 1ns/1ps

module operand_forwarder import hart_pkg::*; (
    input  reg_index_t source_index,
    input  word_t      register_value,
    input  logic       mem_stage_valid,
    input  logic       mem_stage_reg_write,
    input  reg_index_t mem_stage_rd,
    input  logic       mem_stage_is_load,
    input  word_t      mem_stage_result,
    input  logic       wb_stage_valid,
    input  logic       wb_stage_reg_write,
    input  reg_index_t wb_stage_rd,
    input  word_t      wb_stage_value,
    output logic       available,
    output word_t      operand
);

    logic mem_hit;
    logic wb_hit;

    assign mem_hit = mem_stage_valid && mem_stage_reg_write
                  && mem_stage_rd != '0 && mem_stage_rd == source_index;
    assign wb_hit  = wb_stage_valid && wb_stage_reg_write
                  && wb_stage_rd != '0 && wb_stage_rd == source_index;

    // Youngest producer wins
    always_comb begin
        if (mem_hit) begin
            // Load data not back from the RAM yet
            available = !mem_stage_is_load;
            operand   = mem_stage_result;
        end else if (wb_hit) begin
            available = 1'b1;
            operand   = wb_stage_value;
        end else begin
            available = 1'b1;
            operand   = register_value;
        end
    end

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit import hart_pkg::*; (
    input  op_t   op,
    input  word_t pc,
    input  word_t rs1_value,
    input  word_t rs2_value,
    input  word_t immediate,
    output word_t result,
    output logic  jump_taken,
    output word_t jump_target
);

    always_comb begin
        case (op)
            op_add:  result = rs1_value + rs2_value;
            op_sub:  result = rs1_value - rs2_value;
            // Loads and stores use the sum as the data address
            op_addi,
            op_lw,
            op_sw:   result = rs1_value + immediate;
            op_jal:  result = pc + 32'd4;
            default: result = '0;
        endcase
    end

    assign jump_taken  = (op == op_jal);
    assign jump_target = pc + immediate;

endmodule

// ==== source/data_memory.sv ====
`timescale 1ns/1ps

module data_memory import hart_pkg::*; #(
    parameter int dmem_words = 64
) (
    input  logic  clock,
    input  word_t address,
    input  logic  write_enable,
    input  word_t write_data,
    output word_t read_data
);

    localparam int addr_bits = $clog2(dmem_words);

    word_t ram [dmem_words];
    logic [addr_bits-1:0] word_index;

    assign word_index = address[addr_bits+1:2];

    // Read returns the old word on a same-cycle write
    always_ff @(posedge clock) begin
        if (write_enable) begin
            ram[word_index] <= write_data;
        end
        read_data <= ram[word_index];
    end

endmodule

// ==== source/hart.sv ====
`timescale 1ns/1ps

module hart import hart_pkg::*; #(
    parameter word_t reset_vector = '0,
    parameter int    imem_words   = 64,
    parameter int    dmem_words   = 64
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  imem_write_enable,
    input  word_t imem_write_addr,
    input  word_t imem_write_data,
    output logic  store_valid,
    output word_t store_addr,
    output word_t store_data
);

    word_t pc;
    word_t next_pc;
    logic  stall;
    logic  is_jumping;
    logic  hold_active;
    word_t rom_data;

    logic             s2_valid;
    word_t            s2_pc;
    logic [ilen-1:0]  s2_instr_bits;
    logic [ilen-1:0]  s2_instr_held;
    op_t              dec_op;
    reg_index_t       dec_rs1;
    reg_index_t       dec_rs2;
    reg_index_t       dec_rd;
    word_t            dec_immediate;
    logic             dec_reg_write;
    wb_source_t       dec_wb_source;
    word_t            rf_rs1_value;
    word_t            rf_rs2_value;

    logic       s3_valid;
    word_t      s3_pc;
    op_t        s3_op;
    reg_index_t s3_rs1;
    reg_index_t s3_rs2;
    reg_index_t s3_rd;
    word_t      s3_immediate;
    logic       s3_reg_write;
    wb_source_t s3_wb_source;
    word_t      s3_rs1_raw;
    word_t      s3_rs2_raw;
    word_t      s3_rs1_held;
    word_t      s3_rs2_held;
    word_t      s3_rs1_value;
    word_t      s3_rs2_value;
    logic       s3_rs1_available;
    logic       s3_rs2_available;
    word_t      ex_result;
    logic       ex_jump_taken;
    word_t      ex_jump_target;

    logic       s4_valid;
    word_t      s4_result;
    word_t      s4_store_data;
    reg_index_t s4_rd;
    logic       s4_reg_write;
    logic       s4_is_store;
    logic       s4_is_load;
    wb_source_t s4_wb_source;

    logic       s5_valid;
    word_t      s5_result;
    reg_index_t s5_rd;
    logic       s5_reg_write;
    wb_source_t s5_wb_source;
    word_t      dmem_read_data;
    logic       rf_write_enable;
    reg_index_t rf_write_index;
    word_t      rf_write_value;

    assign stall      = s3_valid && (!s3_rs1_available || !s3_rs2_available);
    assign is_jumping = s3_valid && ex_jump_taken;

    always_comb begin
        if (stall) next_pc = pc;
        else if (is_jumping) next_pc = ex_jump_target;
        else next_pc = pc + 32'd4;
    end

    // ==========================================================================
    // Fetch
    // ==========================================================================
    always_ff @(posedge clock) begin
        if (reset) pc <= reset_vector;
        else pc <= next_pc;
    end

    // ROM is mapped from the reset vector
    instruction_memory #(.imem_words(imem_words)) u_imem (
        .clock        (clock),
        .write_enable (imem_write_enable),
        .write_addr   (imem_write_addr),
        .write_data   (imem_write_data),
        .read_addr    (pc - reset_vector),
        .read_data    (rom_data)
    );

    // ==========================================================================
    // Register read
    // ==========================================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s2_valid <= !is_jumping;
            s2_pc    <= pc;
        end
    end

    // Synchronous reads move on during a stall, so the first stalled
    // cycle's values are kept and replayed until the stall clears
    always_ff @(posedge clock) begin
        if (reset) hold_active <= 1'b0;
        else hold_active <= stall;
        s2_instr_held <= s2_instr_bits;
        s3_rs1_held   <= s3_rs1_value;
        s3_rs2_held   <= s3_rs2_value;
    end

    assign s2_instr_bits = hold_active ? s2_instr_held : rom_data;
    assign s3_rs1_raw    = hold_active ? s3_rs1_held : rf_rs1_value;
    assign s3_rs2_raw    = hold_active ? s3_rs2_held : rf_rs2_value;

    instruction_decoder u_decoder (
        .instruction (s2_instr_bits),
        .op          (dec_op),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .rd          (dec_rd),
        .immediate   (dec_immediate),
        .reg_write   (dec_reg_write),
        .wb_source   (dec_wb_source)
    );

    register_file u_regfile (
        .clock        (clock),
        .reset        (reset),
        .rs1          (dec_rs1),
        .rs2          (dec_rs2),
        .write_enable (rf_write_enable),
        .write_index  (rf_write_index),
        .write_value  (rf_write_value),
        .rs1_value    (rf_rs1_value),
        .rs2_value    (rf_rs2_value)
    );

    // ==========================================================================
    // Compute
    // ==========================================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            s3_valid <= 1'b0;
        end else if (!stall) begin
            s3_valid     <= s2_valid && !is_jumping && (dec_op != op_unknown);
            s3_pc        <= s2_pc;
            s3_op        <= dec_op;
            s3_rs1       <= dec_rs1;
            s3_rs2       <= dec_rs2;
            s3_rd        <= dec_rd;
            s3_immediate <= dec_immediate;
            s3_reg_write <= dec_reg_write;
            s3_wb_source <= dec_wb_source;
        end
    end

    operand_forwarder u_rs1_forwarder (
        .source_index        (s3_rs1),
        .register_value      (s3_rs1_raw),
        .mem_stage_valid     (s4_valid),
        .mem_stage_reg_write (s4_reg_write),
        .mem_stage_rd        (s4_rd),
        .mem_stage_is_load   (s4_is_load),
        .mem_stage_result    (s4_result),
        .wb_stage_valid      (s5_valid),
        .wb_stage_reg_write  (s5_reg_write),
        .wb_stage_rd         (s5_rd),
        .wb_stage_value      (rf_write_value),
        .available           (s3_rs1_available),
        .operand             (s3_rs1_value)
    );

    operand_forwarder u_rs2_forwarder (
        .source_index        (s3_rs2),
        .register_value      (s3_rs2_raw),
        .mem_stage_valid     (s4_valid),
        .mem_stage_reg_write (s4_reg_write),
        .mem_stage_rd        (s4_rd),
        .mem_stage_is_load   (s4_is_load),
        .mem_stage_result    (s4_result),
        .wb_stage_valid      (s5_valid),
        .wb_stage_reg_write  (s5_reg_write),
        .wb_stage_rd         (s5_rd),
        .wb_stage_value      (rf_write_value),
        .available           (s3_rs2_available),
        .operand             (s3_rs2_value)
    );

    execute_unit u_execute (
        .op          (s3_op),
        .pc          (s3_pc),
        .rs1_value   (s3_rs1_value),
        .rs2_value   (s3_rs2_value),
        .immediate   (s3_immediate),
        .result      (ex_result),
        .jump_taken  (ex_jump_taken),
        .jump_target (ex_jump_target)
    );

    // ==========================================================================
    // Memory transaction
    // ==========================================================================
    // A stall leaves a bubble here
    always_ff @(posedge clock) begin
        if (reset || stall) begin
            s4_valid <= 1'b0;
        end else begin
            s4_valid <= s3_valid;
        end
        s4_result     <= ex_result;
        s4_store_data <= s3_rs2_value;
        s4_rd         <= s3_rd;
        s4_reg_write  <= s3_reg_write;
        s4_is_store   <= (s3_op == op_sw);
        s4_wb_source  <= s3_wb_source;
    end

    assign s4_is_load  = (s4_wb_source == wb_from_memory);
    assign store_valid = s4_valid && s4_is_store;
    assign store_addr  = s4_result;
    assign store_data  = s4_store_data;

    data_memory #(.dmem_words(dmem_words)) u_dmem (
        .clock        (clock),
        .address      (s4_result),
        .write_enable (store_valid),
        .write_data   (s4_store_data),
        .read_data    (dmem_read_data)
    );

    // ==========================================================================
    // Writeback
    // ==========================================================================
    always_ff @(posedge clock) begin
        if (reset) s5_valid <= 1'b0;
        else s5_valid <= s4_valid;
        s5_result    <= s4_result;
        s5_rd        <= s4_rd;
        s5_reg_write <= s4_reg_write;
        s5_wb_source <= s4_wb_source;
    end

    assign rf_write_enable = s5_valid && s5_reg_write;
    assign rf_write_index  = s5_rd;
    assign rf_write_value  = (s5_wb_source == wb_from_memory) ? dmem_read_data : s5_result;

endmodule

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int period = 40
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

endmodule

// ==== tests/hart_assertions.sv ====
`timescale 1ns/1ps

module hart_assertions import hart_pkg::*; (
    input logic       clock,
    input logic       reset,
    input logic       store_valid,
    input logic       stall,
    input word_t      pc,
    input logic       s3_valid,
    input reg_index_t s3_rs1,
    input reg_index_t s3_rs2,
    input word_t      s3_rs1_value,
    input word_t      s3_rs2_value
);

    // Stage valid bits clear on every reset edge
    store_quiet_in_reset: assert property (@(posedge clock) reset |=> !store_valid)
        else $error("store_valid high in the cycle after a reset edge");

    // x0 reads zero in compute, whatever was written to it
    x0_rs1_reads_zero: assert property (@(posedge clock) disable iff (reset)
        (s3_valid && s3_rs1 == '0) |-> (s3_rs1_value == '0))
        else $error("rs1 operand for x0 is nonzero");

    x0_rs2_reads_zero: assert property (@(posedge clock) disable iff (reset)
        (s3_valid && s3_rs2 == '0) |-> (s3_rs2_value == '0))
        else $error("rs2 operand for x0 is nonzero");

    pc_holds_on_stall: assert property (@(posedge clock) disable iff (reset)
        stall |=> $stable(pc))
        else $error("PC moved while the pipeline was stalled");

endmodule

bind hart hart_assertions u_assertions (
    .clock        (clock),
    .reset        (reset),
    .store_valid  (store_valid),
    .stall        (stall),
    .pc           (pc),
    .s3_valid     (s3_valid),
    .s3_rs1       (s3_rs1),
    .s3_rs2       (s3_rs2),
    .s3_rs1_value (s3_rs1_value),
    .s3_rs2_value (s3_rs2_value)
);

// ==== tests/hart_tb.sv ====
`timescale 1ns/1ps

module hart_tb import hart_pkg::*; ();

    localparam int clock_period    = 40;
    localparam int reset_cycles    = 16;
    localparam int settle_cycles   = 8;
    localparam int cycles_per_word = 20;

    // Program lengths in words
    localparam int arithmetic_words = 11;
    localparam int load_use_words   = 8;
    localparam int jump_words       = 8;
    localparam int unknown_words    = 7;
    localparam int x0_words         = 7;
    localparam int watchdog_cycles  = cycles_per_word * (arithmetic_words + load_use_words
                                      + jump_words + unknown_words + x0_words);

    logic  clock;
    logic  reset;
    logic  imem_write_enable;
    word_t imem_write_addr;
    word_t imem_write_data;
    logic  store_valid;
    word_t store_addr;
    word_t store_data;

    word_t program_q[$];
    word_t expected_addr_q[$];
    word_t expected_data_q[$];
    word_t store_addr_q[$];
    word_t store_data_q[$];

    logic [31:0] lcg_state    = 32'd89862;
    int          error_count  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    clock_gen #(.period(clock_period)) u_clock_gen (
        .clock (clock)
    );

    hart #(
        .reset_vector (32'h0000_0000),
        .imem_words   (64),
        .dmem_words   (64)
    ) u_dut (
        .clock             (clock),
        .reset             (reset),
        .imem_write_enable (imem_write_enable),
        .imem_write_addr   (imem_write_addr),
        .imem_write_data   (imem_write_data),
        .store_valid       (store_valid),
        .store_addr        (store_addr),
        .store_data        (store_data)
    );

    // Store outputs are registered, so mid-cycle they are steady
    always @(negedge clock) begin
        if (store_valid) begin
            store_addr_q.push_back(store_addr);
            store_data_q.push_back(store_data);
        end
    end

    // ==========================================================================
    // Stimulus helpers
    // ==========================================================================
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [11:0] random_imm();
        logic [31:0] value;
        value = next_random();
        return value[27:16];
    endfunction

    function automatic word_t sign_extend12(input logic [11:0] value);
        return {{20{value[11]}}, value};
    endfunction

    function automatic word_t r_type_word(input logic [6:0] funct7, input reg_index_t rd,
                                          input reg_index_t rs1, input reg_index_t rs2);
        return {funct7, rs2, rs1, 3'b000, rd, opcode_op};
    endfunction

    function automatic word_t i_type_word(input logic [6:0] opcode, input logic [2:0] funct3,
                                          input reg_index_t rd, input reg_index_t rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic word_t sw_word(input reg_index_t rs2, input reg_index_t rs1,
                                      input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcode_store};
    endfunction

    function automatic word_t jal_word(input reg_index_t rd, input logic [20:0] offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, opcode_jal};
    endfunction

    task automatic clear_program();
        program_q.delete();
        expected_addr_q.delete();
        expected_data_q.delete();
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        expected_addr_q.push_back(addr);
        expected_data_q.push_back(data);
    endtask

    task automatic compare_word(input string what, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic watchdog_timer();
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles with tests still running", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    endtask

    // ==========================================================================
    // Load, run and check one program
    // ==========================================================================
    task automatic execute_program(input string test_name);
        int cycles;
        int errors_before;
        int compared;
        int i;
        errors_before = error_count;
        @(negedge clock);
        reset  = 1'b1;
        cycles = 0;
        while (cycles < reset_cycles || cycles < program_q.size()) begin
            if (cycles < program_q.size()) begin
                imem_write_enable = 1'b1;
                imem_write_data   = program_q[cycles];
            end else begin
                imem_write_enable = 1'b0;
            end
            imem_write_addr = word_t'(cycles * 4);
            @(negedge clock);
            cycles++;
        end
        store_addr_q.delete();
        store_data_q.delete();
        imem_write_enable = 1'b0;
        reset             = 1'b0;

        cycles = 0;
        while (store_addr_q.size() < expected_addr_q.size()
               && cycles < cycles_per_word * program_q.size()) begin
            @(posedge clock);
            cycles++;
        end
        // Window for stores that must not appear
        repeat (settle_cycles) @(posedge clock);

        if (store_addr_q.size() != expected_addr_q.size()) begin
            $display("%s: expected %0d stores but the DUT made %0d",
                     test_name, expected_addr_q.size(), store_addr_q.size());
            error_count++;
        end
        compared = (store_addr_q.size() < expected_addr_q.size()) ?
                   store_addr_q.size() : expected_addr_q.size();
        for (i = 0; i < compared; i++) begin
            compare_word($sformatf("%s store %0d address", test_name, i),
                         store_addr_q[i], expected_addr_q[i]);
            compare_word($sformatf("%s store %0d data", test_name, i),
                         store_data_q[i], expected_data_q[i]);
        end
        if (error_count == errors_before) begin
            tests_passed++;
            $display("%s: passed, %0d stores checked", test_name, compared);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, error_count - errors_before);
        end
    endtask

    // ==========================================================================
    // Directed tests
    // ==========================================================================
    task automatic arithmetic_chain();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [11:0] imm_c;
        word_t       sum;
        word_t       diff;
        word_t       total;
        word_t       last;
        imm_a = random_imm();
        imm_b = random_imm();
        imm_c = random_imm();
        sum   = sign_extend12(imm_a) + sign_extend12(imm_b);
        diff  = sum - sign_extend12(imm_a);
        total = diff + sign_extend12(imm_c);
        last  = total - sign_extend12(imm_b);
        clear_program();
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd1, 5'd0, imm_a));
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd2, 5'd0, imm_b));
        program_q.push_back(r_type_word(7'h00, 5'd3, 5'd1, 5'd2));
        program_q.push_back(r_type_word(7'h20, 5'd4, 5'd3, 5'd1));
        program_q.push_back(sw_word(5'd3, 5'd0, 12'd0));
        program_q.push_back(sw_word(5'd4, 5'd0, 12'd4));
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd5, 5'd4, imm_c));
        program_q.push_back(sw_word(5'd5, 5'd0, 12'd8));
        program_q.push_back(r_type_word(7'h20, 5'd6, 5'd5, 5'd2));
        program_q.push_back(sw_word(5'd6, 5'd0, 12'd12));
        program_q.push_back(jal_word(5'd0, 21'd0));
        expect_store(32'd0, sum);
        expect_store(32'd4, diff);
        expect_store(32'd8, total);
        expect_store(32'd12, last);
        execute_program("arithmetic");
    endtask

    task automatic load_use_stall();
        word_t value;
        value = sign_extend12(random_imm());
        clear_program();
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd1, 5'd0, value[11:0]));
        program_q.push_back(sw_word(5'd1, 5'd0, 12'd16));
        program_q.push_back(i_type_word(opcode_load, 3'b010, 5'd2, 5'd0, 12'd16));
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd3, 5'd2, 12'd5));
        program_q.push_back(sw_word(5'd3, 5'd0, 12'd20));
        program_q.push_back(r_type_word(7'h00, 5'd4, 5'd3, 5'd2));
        program_q.push_back(sw_word(5'd4, 5'd0, 12'd24));
        program_q.push_back(jal_word(5'd0, 21'd0));
        expect_store(32'd16, value);
        expect_store(32'd20, value + 32'd5);
        expect_store(32'd24, value + 32'd5 + value);
        execute_program("load-use");
    endtask

    task automatic jump_skips_stores();
        word_t value;
        value = sign_extend12(random_imm());
        clear_program();
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd1, 5'd0, value[11:0]));
        // JAL at byte 4 lands on byte 16
        program_q.push_back(jal_word(5'd5, 21'd12));
        program_q.push_back(sw_word(5'd1, 5'd0, 12'd32));
        program_q.push_back(sw_word(5'd1, 5'd0, 12'd36));
        program_q.push_back(sw_word(5'd5, 5'd0, 12'd40));
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd2, 5'd1, 12'd1));
        program_q.push_back(sw_word(5'd2, 5'd0, 12'd44));
        program_q.push_back(jal_word(5'd0, 21'd0));
        expect_store(32'd40, 32'd8);
        expect_store(32'd44, value + 32'd1);
        execute_program("jump");
    endtask

    task automatic unknown_encoding_ignored();
        word_t value;
        value = sign_extend12(random_imm());
        clear_program();
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd1, 5'd0, value[11:0]));
        // XORI is outside the supported set and would invert x1
        program_q.push_back(i_type_word(opcode_op_imm, 3'b100, 5'd1, 5'd1, 12'hfff));
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd2, 5'd1, 12'd3));
        program_q.push_back(32'hffff_ffff);
        program_q.push_back(sw_word(5'd2, 5'd0, 12'd48));
        program_q.push_back(sw_word(5'd1, 5'd0, 12'd52));
        program_q.push_back(jal_word(5'd0, 21'd0));
        expect_store(32'd48, value + 32'd3);
        expect_store(32'd52, value);
        execute_program("unknown encoding");
    endtask

    task automatic x0_stays_zero();
        logic [11:0] imm;
        imm = random_imm();
        clear_program();
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd0, 5'd0, 12'd291));
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd1, 5'd0, imm));
        program_q.push_back(r_type_word(7'h00, 5'd0, 5'd1, 5'd1));
        program_q.push_back(sw_word(5'd0, 5'd0, 12'd56));
        program_q.push_back(i_type_word(opcode_op_imm, 3'b000, 5'd2, 5'd0, 12'd9));
        program_q.push_back(sw_word(5'd2, 5'd0, 12'd60));
        program_q.push_back(jal_word(5'd0, 21'd0));
        expect_store(32'd56, 32'd0);
        expect_store(32'd60, 32'd9);
        execute_program("register x0");
    endtask

    initial begin
        reset             = 1'b1;
        imem_write_enable = 1'b0;
        imem_write_addr   = '0;
        imem_write_data   = '0;
        fork
            watchdog_timer();
        join_none
        arithmetic_chain();
        load_use_stall();
        jump_skips_stores();
        unknown_encoding_ignored();
        x0_stays_zero();
        $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
source/hart_pkg.sv
source/instruction_memory.sv
source/instruction_decoder.sv
source/register_file.sv
source/operand_forwarder.sv
source/execute_unit.sv
source/data_memory.sv
source/hart.sv
tests/clock_gen.sv
tests/hart_assertions.sv
tests/hart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module hart_tb &&
{ sim_output="$(./obj_dir/Vhart_tb 2>&1)" || true; } &&
printf '%s\n' "$sim_output" &&
printf '%s\n' "$sim_output" | grep -q "Result: PASSED" ||
exit 1
